// File: all.f
+incdir+logic
logic/soc_pkg.sv
logic/wb_bus_if.sv
logic/wb_master_arbiter.sv
logic/wb_slave_decoder.sv
logic/wb_spram.sv
logic/uart_regs.sv
logic/soc_wb_top.sv
tests/soc_wb_tb.sv

// File: tests/soc_wb_tb.sv
/* Testbench acts as CPU data, CPU instruction and debug master and as the UART line.
   RAM words are fully written before any read. Unmapped accesses use region 8'h40. */

`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_wb_tb;

  localparam int MAX_WAIT = 50;
  localparam int SLOTS    = 16;

  logic              wb_clk_i;
  logic              rst_i;
  soc_pkg::wb_addr_t dwb_adr_i, iwb_adr_i, dbg_adr_i;
  soc_pkg::wb_data_t dwb_dat_i, iwb_dat_i, dbg_dat_i;
  soc_pkg::wb_sel_t  dwb_sel_i, iwb_sel_i, dbg_sel_i;
  logic              dwb_we_i, iwb_we_i, dbg_we_i;
  logic              dwb_cyc_i, iwb_cyc_i, dbg_cyc_i;
  logic              dwb_stb_i, iwb_stb_i, dbg_stb_i;
  soc_pkg::wb_data_t dwb_dat_o, iwb_dat_o, dbg_dat_o;
  logic              dwb_ack_o, iwb_ack_o, dbg_ack_o;
  logic              dwb_err_o, iwb_err_o, dbg_err_o;
  logic [7:0]        rx_data_i;
  logic              rx_valid_i;
  logic [7:0]        tx_data_o;
  logic              tx_valid_o;
  logic              irq_o;

  // Reference model and per-master expectations
  soc_pkg::wb_data_t ref_mem [2**`SOC_MEM_AW];
  soc_pkg::wb_data_t exp_dat [3];
  logic              exp_err [3];
  logic              rd_chk  [3];
  logic [7:0]        tx_exp;
  logic              tx_allowed;
  logic              irq_allowed;
  logic              quiet_chk;
  logic              wait_dbg;
  logic              wait_dwb;
  int                tx_count;
  int                fail_count;
  integer            seed;

  soc_wb_top i_soc_wb_top (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    if (tx_valid_o === 1'b1) begin
      tx_count <= tx_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////
  task automatic report_fail(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    fail_count++;
    $display("FAIL at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic report_stuck(input string what);
    fail_count++;
    $display("Error at %0t ns: %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped on timeout");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  a_reset_bus : assert property (@(posedge wb_clk_i) quiet_chk |->
    ({dwb_ack_o, dwb_err_o, iwb_ack_o, iwb_err_o, dbg_ack_o, dbg_err_o} == 6'b0))
    else report_fail("{dwb,iwb,dbg}_{ack,err}_o", 32'h0, $sampled(
      {dwb_ack_o, dwb_err_o, iwb_ack_o, iwb_err_o, dbg_ack_o, dbg_err_o}));
  a_reset_uart : assert property (@(posedge wb_clk_i)
    quiet_chk |-> ({tx_valid_o, irq_o} == 2'b00))
    else report_fail("{tx_valid_o,irq_o}", 32'h0, $sampled({tx_valid_o, irq_o}));

  a_dwb_rdata : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (dwb_ack_o && rd_chk[0]) |-> (dwb_dat_o == exp_dat[0]))
    else report_fail("dwb_dat_o", $sampled(exp_dat[0]), $sampled(dwb_dat_o));
  a_iwb_rdata : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (iwb_ack_o && rd_chk[1]) |-> (iwb_dat_o == exp_dat[1]))
    else report_fail("iwb_dat_o", $sampled(exp_dat[1]), $sampled(iwb_dat_o));
  a_dbg_rdata : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (dbg_ack_o && rd_chk[2]) |-> (dbg_dat_o == exp_dat[2]))
    else report_fail("dbg_dat_o", $sampled(exp_dat[2]), $sampled(dbg_dat_o));

  // Each response must be the kind the access asked for
  a_dwb_resp : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (dwb_ack_o || dwb_err_o) |-> ({dwb_ack_o, dwb_err_o} == {~exp_err[0], exp_err[0]}))
    else report_fail("{dwb_ack_o,dwb_err_o}", $sampled({~exp_err[0], exp_err[0]}),
                     $sampled({dwb_ack_o, dwb_err_o}));
  a_iwb_resp : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (iwb_ack_o || iwb_err_o) |-> ({iwb_ack_o, iwb_err_o} == {~exp_err[1], exp_err[1]}))
    else report_fail("{iwb_ack_o,iwb_err_o}", $sampled({~exp_err[1], exp_err[1]}),
                     $sampled({iwb_ack_o, iwb_err_o}));
  a_dbg_resp : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (dbg_ack_o || dbg_err_o) |-> ({dbg_ack_o, dbg_err_o} == {~exp_err[2], exp_err[2]}))
    else report_fail("{dbg_ack_o,dbg_err_o}", $sampled({~exp_err[2], exp_err[2]}),
                     $sampled({dbg_ack_o, dbg_err_o}));

  // Loser of arbitration stays silent while the winner holds cyc
  a_dbg_waits : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (wait_dbg && dwb_cyc_i) |-> !(dbg_ack_o || dbg_err_o))
    else report_fail("dbg_ack_o", 32'h0, $sampled(dbg_ack_o));
  a_dwb_waits : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (wait_dwb && dbg_cyc_i) |-> !(dwb_ack_o || dwb_err_o))
    else report_fail("dwb_ack_o", 32'h0, $sampled(dwb_ack_o));

  a_tx_expected : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    tx_valid_o |-> tx_allowed)
    else report_fail("tx_valid_o", 32'h0, $sampled(tx_valid_o));
  a_tx_data : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    tx_valid_o |-> (tx_data_o == tx_exp))
    else report_fail("tx_data_o", $sampled(tx_exp), $sampled(tx_data_o));
  a_irq_expected : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    irq_o |-> irq_allowed)
    else report_fail("irq_o", 32'h0, $sampled(irq_o));

  ////////////////////////////////////////////////////////////////////////////
  // Bus helpers start and end on a falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic drive_req(input soc_pkg::mst_e m, input logic req, input logic we,
                           input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t dat,
                           input soc_pkg::wb_sel_t sel);
    case (m)
      soc_pkg::MST_DATA: begin
        dwb_cyc_i = req;
        dwb_stb_i = req;
        dwb_we_i  = we;
        dwb_adr_i = adr;
        dwb_dat_i = dat;
        dwb_sel_i = sel;
      end
      soc_pkg::MST_INSN: begin
        iwb_cyc_i = req;
        iwb_stb_i = req;
        iwb_we_i  = we;
        iwb_adr_i = adr;
        iwb_dat_i = dat;
        iwb_sel_i = sel;
      end
      default: begin
        dbg_cyc_i = req;
        dbg_stb_i = req;
        dbg_we_i  = we;
        dbg_adr_i = adr;
        dbg_dat_i = dat;
        dbg_sel_i = sel;
      end
    endcase
  endtask

  function automatic logic resp_seen(input soc_pkg::mst_e m);
    case (m)
      soc_pkg::MST_DATA: return dwb_ack_o | dwb_err_o;
      soc_pkg::MST_INSN: return iwb_ack_o | iwb_err_o;
      default:           return dbg_ack_o | dbg_err_o;
    endcase
  endfunction

  task automatic run_cycle(input soc_pkg::mst_e m, input logic we,
                           input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t dat,
                           input soc_pkg::wb_sel_t sel);
    int waited;
    waited = 0;
    drive_req(m, 1'b1, we, adr, dat, sel);
    do begin
      @(posedge wb_clk_i);
      waited++;
      if (!resp_seen(m) && waited >= MAX_WAIT) begin
        report_stuck($sformatf("master %s saw no ack or err", m.name()));
      end
    end while (!resp_seen(m));
    @(negedge wb_clk_i);
    drive_req(m, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic write_word(input soc_pkg::mst_e m, input soc_pkg::wb_addr_t adr,
                            input soc_pkg::wb_data_t dat, input soc_pkg::wb_sel_t sel);
    logic [`SOC_MEM_AW-1:0] idx;
    idx = adr[`SOC_MEM_AW+1:2];
    exp_err[m] = 1'b0;
    rd_chk[m]  = 1'b0;
    if (adr[31:24] == `SOC_MEM_REGION) begin
      for (int b = 0; b < `SOC_SELW; b++) begin
        if (sel[b]) begin
          ref_mem[idx][8*b +: 8] = dat[8*b +: 8];
        end
      end
    end
    run_cycle(m, 1'b1, adr, dat, sel);
  endtask

  task automatic read_check(input soc_pkg::mst_e m, input soc_pkg::wb_addr_t adr,
                            input soc_pkg::wb_data_t expected);
    exp_err[m] = 1'b0;
    exp_dat[m] = expected;
    rd_chk[m]  = 1'b1;
    run_cycle(m, 1'b0, adr, '0, 4'hF);
    rd_chk[m]  = 1'b0;
  endtask

  task automatic err_check(input soc_pkg::mst_e m, input soc_pkg::wb_addr_t adr);
    exp_err[m] = 1'b1;
    rd_chk[m]  = 1'b0;
    run_cycle(m, 1'b0, adr, '0, 4'hF);
    exp_err[m] = 1'b0;
  endtask

  task automatic wait_irq(input logic level);
    int waited;
    waited = 0;
    while (irq_o !== level) begin
      @(negedge wb_clk_i);
      waited++;
      if (irq_o !== level && waited >= MAX_WAIT) begin
        report_stuck($sformatf("irq_o did not reach %b", level));
      end
    end
  endtask

  function automatic soc_pkg::wb_addr_t mem_adr(input int slot);
    return {`SOC_MEM_REGION, 22'(slot * 5 + 3), 2'b00};
  endfunction

  function automatic soc_pkg::wb_addr_t uart_adr(input logic [2:0] reg_num);
    return {`SOC_UART_REGION, 19'd0, reg_num, 2'b00};
  endfunction

  function automatic soc_pkg::wb_data_t ref_word(input soc_pkg::wb_addr_t adr);
    return ref_mem[adr[`SOC_MEM_AW+1:2]];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    soc_pkg::wb_data_t v;
    int                slot;
    int                cnt0;
    logic [7:0]        rx_byte;
    seed        = 79270;
    rst_i       = 1'b1;
    rx_data_i   = 8'h00;
    rx_valid_i  = 1'b0;
    tx_exp      = 8'h00;
    tx_allowed  = 1'b0;
    irq_allowed = 1'b0;
    quiet_chk   = 1'b0;
    wait_dbg    = 1'b0;
    wait_dwb    = 1'b0;
    tx_count    = 0;
    fail_count  = 0;
    for (int m = 0; m < 3; m++) begin
      exp_dat[m] = '0;
      exp_err[m] = 1'b0;
      rd_chk[m]  = 1'b0;
    end
    drive_req(soc_pkg::MST_DATA, 1'b0, 1'b0, '0, '0, '0);
    drive_req(soc_pkg::MST_INSN, 1'b0, 1'b0, '0, '0, '0);
    drive_req(soc_pkg::MST_DBG, 1'b0, 1'b0, '0, '0, '0);

    // Five rising edges in reset and two idle cycles after it under watch
    @(negedge wb_clk_i);
    quiet_chk = 1'b1;
    repeat (4) @(negedge wb_clk_i);
    rst_i = 1'b0;
    repeat (2) @(negedge wb_clk_i);
    quiet_chk = 1'b0;

    // RAM gets full words first and then random lanes
    for (int i = 0; i < SLOTS; i++) begin
      write_word(soc_pkg::MST_DATA, mem_adr(i), $random(seed), 4'hF);
    end
    for (int i = 0; i < 2 * SLOTS; i++) begin
      slot = $unsigned($random(seed)) % SLOTS;
      write_word(soc_pkg::MST_DATA, mem_adr(slot), $random(seed), 4'($random(seed)));
    end
    for (int i = 0; i < SLOTS; i++) begin
      read_check(soc_pkg::MST_DATA, mem_adr(i), ref_word(mem_adr(i)));
    end

    // Same words seen from the other two masters
    for (int i = 0; i < SLOTS; i++) begin
      read_check(soc_pkg::MST_INSN, mem_adr(i), ref_word(mem_adr(i)));
      read_check(soc_pkg::MST_DBG, mem_adr(i), ref_word(mem_adr(i)));
    end

    err_check(soc_pkg::MST_DATA, 32'h4000_0010);
    err_check(soc_pkg::MST_INSN, 32'h4000_0100);

    // UART scratch and transmit
    v = $random(seed);
    write_word(soc_pkg::MST_DATA, uart_adr(`SOC_UART_SCR), v, 4'h1);
    read_check(soc_pkg::MST_DATA, uart_adr(`SOC_UART_SCR), {24'h0, v[7:0]});
    v          = $random(seed);
    tx_exp     = v[7:0];
    tx_allowed = 1'b1;
    cnt0       = tx_count;
    write_word(soc_pkg::MST_DATA, uart_adr(`SOC_UART_RBR_THR), v, 4'h1);
    @(negedge wb_clk_i);
    a_tx_once : assert (tx_count == cnt0 + 1)
      else report_fail("tx_count", cnt0 + 1, tx_count);
    tx_allowed = 1'b0;

    // Receive interrupt
    write_word(soc_pkg::MST_DATA, uart_adr(`SOC_UART_IER), 32'h1, 4'h1);
    irq_allowed = 1'b1;
    rx_byte     = 8'($random(seed));
    rx_data_i   = rx_byte;
    rx_valid_i  = 1'b1;
    @(negedge wb_clk_i);
    rx_valid_i  = 1'b0;
    wait_irq(1'b1);
    read_check(soc_pkg::MST_DATA, uart_adr(`SOC_UART_LSR), 32'h21);
    read_check(soc_pkg::MST_DATA, uart_adr(`SOC_UART_RBR_THR), {24'h0, rx_byte});
    wait_irq(1'b0);
    irq_allowed = 1'b0;

    // Data and debug request together and data goes first
    v = $random(seed);
    wait_dbg = 1'b1;
    fork
      write_word(soc_pkg::MST_DATA, mem_adr(0), v, 4'hF);
      read_check(soc_pkg::MST_DBG, mem_adr(0), v);
    join
    wait_dbg = 1'b0;

    // Debug owns the idle bus and data arrives one cycle later
    v = $random(seed);
    wait_dwb = 1'b1;
    fork
      write_word(soc_pkg::MST_DBG, mem_adr(1), v, 4'hF);
      begin
        @(negedge wb_clk_i);
        read_check(soc_pkg::MST_DATA, mem_adr(1), v);
      end
    join
    wait_dwb = 1'b0;
    read_check(soc_pkg::MST_INSN, mem_adr(0), ref_word(mem_adr(0)));
    read_check(soc_pkg::MST_INSN, mem_adr(1), ref_word(mem_adr(1)));

    repeat (2) @(negedge wb_clk_i);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: logic/soc_wb_top.sv
/* Wishbone tile with three external masters, main RAM and UART registers.
   Masters are held off by arbitration, never by retry. */

`timescale 1ns/1ps

module soc_wb_top (
  input  logic              wb_clk_i,
  input  logic              rst_i,
  // CPU data port
  input  soc_pkg::wb_addr_t dwb_adr_i,
  input  soc_pkg::wb_data_t dwb_dat_i,
  input  soc_pkg::wb_sel_t  dwb_sel_i,
  input  logic              dwb_we_i,
  input  logic              dwb_cyc_i,
  input  logic              dwb_stb_i,
  output soc_pkg::wb_data_t dwb_dat_o,
  output logic              dwb_ack_o,
  output logic              dwb_err_o,
  // CPU instruction port
  input  soc_pkg::wb_addr_t iwb_adr_i,
  input  soc_pkg::wb_data_t iwb_dat_i,
  input  soc_pkg::wb_sel_t  iwb_sel_i,
  input  logic              iwb_we_i,
  input  logic              iwb_cyc_i,
  input  logic              iwb_stb_i,
  output soc_pkg::wb_data_t iwb_dat_o,
  output logic              iwb_ack_o,
  output logic              iwb_err_o,
  // Debug master
  input  soc_pkg::wb_addr_t dbg_adr_i,
  input  soc_pkg::wb_data_t dbg_dat_i,
  input  soc_pkg::wb_sel_t  dbg_sel_i,
  input  logic              dbg_we_i,
  input  logic              dbg_cyc_i,
  input  logic              dbg_stb_i,
  output soc_pkg::wb_data_t dbg_dat_o,
  output logic              dbg_ack_o,
  output logic              dbg_err_o,
  // UART side
  input  logic [7:0]        rx_data_i,
  input  logic              rx_valid_i,
  output logic [7:0]        tx_data_o,
  output logic              tx_valid_o,
  output logic              irq_o
);

  wb_bus_if bus_arb ();
  wb_bus_if bus_mem ();
  wb_bus_if bus_uart ();

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////
  // Master groups match by name
  wb_master_arbiter i_arbiter (
    .bus (bus_arb),
    .*
  );

  wb_slave_decoder i_decoder (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .up       (bus_arb),
    .mem      (bus_mem),
    .uart     (bus_uart)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slaves
  ////////////////////////////////////////////////////////////////////////////
  wb_spram i_spram (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .bus      (bus_mem)
  );

  uart_regs i_uart (
    .wb_clk_i   (wb_clk_i),
    .rst_i      (rst_i),
    .bus        (bus_uart),
    .rx_data_i  (rx_data_i),
    .rx_valid_i (rx_valid_i),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o),
    .irq_o      (irq_o)
  );

endmodule

// File: logic/uart_regs.sv
/* UART register subset on byte lane 0, serial line replaced by strobes.
   Only the receive data-ready interrupt exists. */

`timescale 1ns/1ps
`include "soc_defs.svh"

module uart_regs (
  input  logic       wb_clk_i,
  input  logic       rst_i,
  wb_bus_if.slave    bus,
  input  logic [7:0] rx_data_i,
  input  logic       rx_valid_i,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o,
  output logic       irq_o
);

  soc_pkg::wb_addr_u addr_u;
  logic [2:0]        reg_num;
  logic              access;
  logic              wr;
  logic              rd;
  logic              ack_q;
  logic              dr_q;
  logic              ier_q;
  logic              tx_valid_q;
  logic [7:0]        rx_data_q;
  logic [7:0]        scr_q;
  logic [7:0]        tx_data_q;
  logic [7:0]        rd_q;

  assign addr_u  = bus.adr;
  assign reg_num = addr_u.uart.reg_num;
  assign access  = bus.cyc & bus.stb & ~ack_q;
  assign wr      = access & bus.we & bus.sel[0];
  assign rd      = access & ~bus.we;

  ////////////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q      <= 1'b0;
      dr_q       <= 1'b0;
      ier_q      <= 1'b0;
      tx_valid_q <= 1'b0;
    end else begin
      ack_q      <= access;
      tx_valid_q <= wr && (reg_num == `SOC_UART_RBR_THR);
      if (wr && (reg_num == `SOC_UART_IER)) begin
        ier_q <= bus.dat_m2s[0];
      end
      // A new byte wins over a read in the same cycle
      if (rx_valid_i) begin
        dr_q <= 1'b1;
      end else if (rd && (reg_num == `SOC_UART_RBR_THR)) begin
        dr_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rx_valid_i) begin
      rx_data_q <= rx_data_i;
    end
    if (wr && (reg_num == `SOC_UART_SCR)) begin
      scr_q <= bus.dat_m2s[7:0];
    end
    if (wr && (reg_num == `SOC_UART_RBR_THR)) begin
      tx_data_q <= bus.dat_m2s[7:0];
    end
    if (rd) begin
      case (reg_num)
        `SOC_UART_RBR_THR: rd_q <= rx_data_q;
        `SOC_UART_IER:     rd_q <= {7'b0, ier_q};
        `SOC_UART_LSR:     rd_q <= {2'b00, 1'b1, 4'b0000, dr_q}; // bit 5 THR empty
        `SOC_UART_SCR:     rd_q <= scr_q;
        default:           rd_q <= 8'h00;
      endcase
    end
  end

  assign bus.ack     = ack_q;
  assign bus.err     = 1'b0;
  assign bus.dat_s2m = {{(`SOC_DW-8){1'b0}}, rd_q};

  assign tx_data_o  = tx_data_q;
  assign tx_valid_o = tx_valid_q;
  assign irq_o      = ier_q & dr_q;

endmodule

// File: logic/wb_spram.sv
/* Single-port RAM of 2^SOC_MEM_AW words, aliased inside its region.
   One access takes two cycles with a registered ack. */

`timescale 1ns/1ps
`include "soc_defs.svh"

module wb_spram (
  input  logic    wb_clk_i,
  input  logic    rst_i,
  wb_bus_if.slave bus
);

  soc_pkg::wb_data_t     ram [2**`SOC_MEM_AW];
  soc_pkg::wb_addr_u     addr_u;
  logic [`SOC_MEM_AW-1:0] mem_idx;
  soc_pkg::wb_data_t     rd_q;
  logic                  ack_q;
  logic                  access;

  assign addr_u  = bus.adr;
  assign mem_idx = addr_u.mem.word[`SOC_MEM_AW-1:0];

  // New access only when no ack is pending
  assign access = bus.cyc & bus.stb & ~ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      if (bus.we) begin
        for (int i = 0; i < `SOC_SELW; i++) begin
          if (bus.sel[i]) begin
            ram[mem_idx][8*i +: 8] <= bus.dat_m2s[8*i +: 8];
          end
        end
      end
      rd_q <= ram[mem_idx];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign bus.ack     = ack_q;
  assign bus.err     = 1'b0;
  assign bus.dat_s2m = rd_q;

  // Acked request is still on the bus unchanged
  a_ack_after_stb : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    bus.ack |-> (bus.cyc && bus.stb && $stable(bus.adr)));

endmodule

// File: logic/wb_slave_decoder.sv
/* Routes on the top address byte to RAM or UART.
   Any other region gets err one cycle after stb. */

`timescale 1ns/1ps
`include "soc_defs.svh"

module wb_slave_decoder (
  input  logic     wb_clk_i,
  input  logic     rst_i,
  wb_bus_if.slave  up,
  wb_bus_if.master mem,
  wb_bus_if.master uart
);

  soc_pkg::wb_addr_u addr_u;
  logic              hit_mem;
  logic              hit_uart;
  logic              err_q;

  assign addr_u   = up.adr;
  assign hit_mem  = (addr_u.mem.region == `SOC_MEM_REGION);
  assign hit_uart = (addr_u.uart.region == `SOC_UART_REGION);

  ////////////////////////////////////////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////////////////////////////////////////
  assign mem.adr     = up.adr;
  assign mem.dat_m2s = up.dat_m2s;
  assign mem.sel     = up.sel;
  assign mem.we      = up.we;
  assign mem.cyc     = up.cyc & hit_mem;
  assign mem.stb     = up.stb & hit_mem;

  assign uart.adr     = up.adr;
  assign uart.dat_m2s = up.dat_m2s;
  assign uart.sel     = up.sel;
  assign uart.we      = up.we;
  assign uart.cyc     = up.cyc & hit_uart;
  assign uart.stb     = up.stb & hit_uart;

  // Unmapped access, dropped the cycle after it fires
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= up.cyc & up.stb & ~hit_mem & ~hit_uart & ~err_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////////////////////
  assign up.dat_s2m = hit_uart ? uart.dat_s2m :
                      hit_mem  ? mem.dat_s2m  : '0;
  assign up.ack     = mem.ack | uart.ack;
  assign up.err     = err_q | mem.err | uart.err;

  a_ack_err_excl : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(up.ack && up.err));

endmodule

// File: logic/wb_master_arbiter.sv
/* Fixed priority data > insn > debug with the grant held while cyc stays high.
   Waiting masters see neither ack nor err. */

`timescale 1ns/1ps

module wb_master_arbiter (
  input  logic              wb_clk_i,
  input  logic              rst_i,
  input  soc_pkg::wb_addr_t dwb_adr_i,
  input  soc_pkg::wb_data_t dwb_dat_i,
  input  soc_pkg::wb_sel_t  dwb_sel_i,
  input  logic              dwb_we_i,
  input  logic              dwb_cyc_i,
  input  logic              dwb_stb_i,
  output soc_pkg::wb_data_t dwb_dat_o,
  output logic              dwb_ack_o,
  output logic              dwb_err_o,
  input  soc_pkg::wb_addr_t iwb_adr_i,
  input  soc_pkg::wb_data_t iwb_dat_i,
  input  soc_pkg::wb_sel_t  iwb_sel_i,
  input  logic              iwb_we_i,
  input  logic              iwb_cyc_i,
  input  logic              iwb_stb_i,
  output soc_pkg::wb_data_t iwb_dat_o,
  output logic              iwb_ack_o,
  output logic              iwb_err_o,
  input  soc_pkg::wb_addr_t dbg_adr_i,
  input  soc_pkg::wb_data_t dbg_dat_i,
  input  soc_pkg::wb_sel_t  dbg_sel_i,
  input  logic              dbg_we_i,
  input  logic              dbg_cyc_i,
  input  logic              dbg_stb_i,
  output soc_pkg::wb_data_t dbg_dat_o,
  output logic              dbg_ack_o,
  output logic              dbg_err_o,
  wb_bus_if.master          bus
);

  soc_pkg::mst_e owner_q;
  soc_pkg::mst_e cur;
  logic          busy_q;
  logic          owner_cyc;
  logic          hold;

  ////////////////////////////////////////////////////////////////////////////
  // Grant selection
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (owner_q)
      soc_pkg::MST_DATA: owner_cyc = dwb_cyc_i;
      soc_pkg::MST_INSN: owner_cyc = iwb_cyc_i;
      default:           owner_cyc = dbg_cyc_i;
    endcase
    hold = busy_q && owner_cyc;
    // Idle bus goes to the highest requester in the same cycle
    if (hold)           cur = owner_q;
    else if (dwb_cyc_i) cur = soc_pkg::MST_DATA;
    else if (iwb_cyc_i) cur = soc_pkg::MST_INSN;
    else                cur = soc_pkg::MST_DBG;
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= soc_pkg::MST_DATA;
    end else begin
      busy_q  <= bus.cyc;
      owner_q <= cur;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cur)
      soc_pkg::MST_DATA: begin
        bus.adr     = dwb_adr_i;
        bus.dat_m2s = dwb_dat_i;
        bus.sel     = dwb_sel_i;
        bus.we      = dwb_we_i;
        bus.cyc     = dwb_cyc_i;
        bus.stb     = dwb_stb_i;
      end
      soc_pkg::MST_INSN: begin
        bus.adr     = iwb_adr_i;
        bus.dat_m2s = iwb_dat_i;
        bus.sel     = iwb_sel_i;
        bus.we      = iwb_we_i;
        bus.cyc     = iwb_cyc_i;
        bus.stb     = iwb_stb_i;
      end
      default: begin
        bus.adr     = dbg_adr_i;
        bus.dat_m2s = dbg_dat_i;
        bus.sel     = dbg_sel_i;
        bus.we      = dbg_we_i;
        bus.cyc     = dbg_cyc_i;
        bus.stb     = dbg_stb_i;
      end
    endcase
  end

  // Response goes back to the current owner only
  assign dwb_ack_o = bus.ack && (cur == soc_pkg::MST_DATA);
  assign dwb_err_o = bus.err && (cur == soc_pkg::MST_DATA);
  assign dwb_dat_o = (cur == soc_pkg::MST_DATA) ? bus.dat_s2m : '0;
  assign iwb_ack_o = bus.ack && (cur == soc_pkg::MST_INSN);
  assign iwb_err_o = bus.err && (cur == soc_pkg::MST_INSN);
  assign iwb_dat_o = (cur == soc_pkg::MST_INSN) ? bus.dat_s2m : '0;
  assign dbg_ack_o = bus.ack && (cur == soc_pkg::MST_DBG);
  assign dbg_err_o = bus.err && (cur == soc_pkg::MST_DBG);
  assign dbg_dat_o = (cur == soc_pkg::MST_DBG) ? bus.dat_s2m : '0;

  // A request still waiting for its response keeps the bus
  a_owner_held : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (bus.cyc && bus.stb && !bus.ack && !bus.err) |=> (cur == $past(cur)));

endmodule

// File: logic/wb_bus_if.sv
/* Wishbone classic bus, no bursts and no retry.
   Request is held until ack or err. */

`timescale 1ns/1ps

interface wb_bus_if;

  // Master to slave
  soc_pkg::wb_addr_t adr;
  soc_pkg::wb_data_t dat_m2s;
  soc_pkg::wb_sel_t  sel;
  logic              we;
  logic              cyc;
  logic              stb;

  // Slave to master
  soc_pkg::wb_data_t dat_s2m;
  logic              ack;
  logic              err;

  modport master (
    output adr, dat_m2s, sel, we, cyc, stb,
    input  dat_s2m, ack, err
  );

  modport slave (
    input  adr, dat_m2s, sel, we, cyc, stb,
    output dat_s2m, ack, err
  );

endinterface

// File: logic/soc_pkg.sv
/* Bus word types and the two address views used by the slaves.
   The union assumes a 32-bit address. */

`include "soc_defs.svh"

package soc_pkg;

  typedef logic [`SOC_AW-1:0]   wb_addr_t;
  typedef logic [`SOC_DW-1:0]   wb_data_t;
  typedef logic [`SOC_SELW-1:0] wb_sel_t;

  // Master index, lower value wins arbitration
  typedef enum logic [1:0] {
    MST_DATA = 2'd0,
    MST_INSN = 2'd1,
    MST_DBG  = 2'd2
  } mst_e;

  typedef struct packed {
    logic [7:0]  region;
    logic [21:0] word;
    logic [1:0]  lane;
  } mem_view_t;

  typedef struct packed {
    logic [7:0]  region;
    logic [18:0] unused;
    logic [2:0]  reg_num;
    logic [1:0]  lane;
  } uart_view_t;

  // Same address word, RAM or UART layout
  typedef union packed {
    mem_view_t  mem;
    uart_view_t uart;
  } wb_addr_u;

endpackage

// File: logic/soc_defs.svh
/* Bus widths, address map and UART offsets for the tile.
   Regions decode on the top address byte only. */

`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////
`define SOC_AW   32
`define SOC_DW   32
`define SOC_SELW 4

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////
// 2^10 words, 4 KiB of main RAM
`define SOC_MEM_AW 10

`define SOC_MEM_REGION  8'h00
`define SOC_UART_REGION 8'h90

////////////////////////////////////////////////////////////////////////////
// UART register numbers
////////////////////////////////////////////////////////////////////////////
`define SOC_UART_RBR_THR 3'd0
`define SOC_UART_IER     3'd1
`define SOC_UART_LSR     3'd5
`define SOC_UART_SCR     3'd7

`endif
